//--- rvfi_tracer.f
+incdir+test
src/rvfi_pkg.sv
src/rvfi_issue_if.sv
src/rvfi_lsu_if.sv
src/rvfi_id_capture.sv
src/rvfi_issue_table.sv
src/rvfi_commit_pack.sv
src/rvfi_tracer.sv
test/tb_rvfi_tracer.sv

//--- Makefile
# Verilator build and run of the trace unit testbench

VERILATOR ?= verilator
TOP       ?= tb_rvfi_tracer
FILELIST  ?= rvfi_tracer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A failing check ends in $fatal, which gives a nonzero exit status
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- test/rvfi_model.svh
// Reference model of the trace unit: instruction holder, issue table and record rules
`ifndef RVFI_MODEL_SVH
`define RVFI_MODEL_SVH

// Included inside the testbench module, reads its input variables directly
logic             m_hold_valid;
rvfi_pkg::insn_t  m_hold_insn;
rvfi_pkg::insn_t  m_insn  [NR_SB_ENTRIES];
rvfi_pkg::xlen_t  m_rs1   [NR_SB_ENTRIES];
rvfi_pkg::xlen_t  m_rs2   [NR_SB_ENTRIES];
rvfi_pkg::vaddr_t m_addr  [NR_SB_ENTRIES];
rvfi_pkg::be_t    m_rmask [NR_SB_ENTRIES];
rvfi_pkg::be_t    m_wmask [NR_SB_ENTRIES];
rvfi_pkg::xlen_t  m_wdata [NR_SB_ENTRIES];

task automatic clear_model();
  m_hold_valid = 1'b0;
  m_hold_insn  = '0;
  for (int i = 0; i < NR_SB_ENTRIES; i++) begin
    m_insn[i]  = '0;
    m_rs1[i]   = '0;
    m_rs2[i]   = '0;
    m_addr[i]  = '0;
    m_rmask[i] = '0;
    m_wmask[i] = '0;
    m_wdata[i] = '0;
  end
endtask

// One rising edge, using the inputs that were stable before it
task automatic clock_model();
  logic take;
  take = fetch_valid && (!m_hold_valid || issue_ack);
  // Issue write sees the word held before this edge
  if (decoded_valid && decoded_ack && !flush_unissued) begin
    m_insn[issue_id]  = m_hold_insn;
    m_rs1[issue_id]   = rs1_fwd;
    m_rs2[issue_id]   = rs2_fwd;
    m_addr[issue_id]  = '0;
    m_rmask[issue_id] = '0;
    m_wmask[issue_id] = '0;
    m_wdata[issue_id] = '0;
  end
  // Memory annotation after the issue write, load before store
  if (lsu_valid && lsu_is_load && lsu_be != 4'h0) begin
    m_addr[lsu_id]  = lsu_addr;
    m_rmask[lsu_id] = lsu_be;
  end else if (lsu_valid && lsu_is_store && lsu_be != 4'h0) begin
    m_addr[lsu_id]  = lsu_addr;
    m_wmask[lsu_id] = lsu_be;
    m_wdata[lsu_id] = lsu_wdata;
  end
  if (issue_ack) m_hold_valid = 1'b0;
  if (take) begin
    m_hold_valid = 1'b1;
    m_hold_insn  = is_compressed ? {16'h0000, fetch_insn[15:0]} : fetch_insn;
  end
  if (flush) m_hold_valid = 1'b0;   // Drops whatever is held
endtask

// Retired unless it trapped with a cause other than an ecall
function automatic logic valid_rule(logic ack, logic cvalid, logic exv, rvfi_pkg::xlen_t cause);
  logic ecall;
  ecall = (cause == 32'd8) || (cause == 32'd9) || (cause == 32'd11);
  return (ack && !exv) || (cvalid && exv && ecall);
endfunction

function automatic rvfi_pkg::priv_t mode_rule(logic dbg, rvfi_pkg::priv_t prv);
  return dbg ? 2'd2 : prv;
endfunction

`endif

//--- test/tb_rvfi_tracer.sv
// Testbench for the trace unit: random probes checked against a reference model
`timescale 1ns/1ps
`default_nettype none

module tb_rvfi_tracer;

  localparam int NR_COMMIT_PORTS = 2;
  localparam int NR_SB_ENTRIES   = 8;
  localparam int ID_W            = 3;
  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 2;
  localparam int NUM_CYCLES      = 2000;
  localparam int TIMEOUT_CYCLES  = RESET_CYCLES + NUM_CYCLES + 100;

  logic clk = 1'b0;
  logic rst_n;
  integer seed;
  int cycle_count = 0;

  // ------------------------------------------------------------------
  // DUT inputs and outputs
  // ------------------------------------------------------------------
  logic fetch_valid, is_compressed, issue_ack, flush;
  logic decoded_valid, decoded_ack, flush_unissued;
  logic ex_valid, debug_mode, lsu_valid, lsu_is_load, lsu_is_store;
  logic [ID_W-1:0] issue_id, lsu_id;
  rvfi_pkg::insn_t fetch_insn;
  rvfi_pkg::xlen_t rs1_fwd, rs2_fwd, ex_cause, lsu_wdata;
  rvfi_pkg::vaddr_t lsu_addr;
  rvfi_pkg::be_t lsu_be;
  rvfi_pkg::priv_t priv;
  logic [NR_COMMIT_PORTS-1:0][ID_W-1:0] commit_ptr;
  logic [NR_COMMIT_PORTS-1:0] commit_ack, commit_valid;
  rvfi_pkg::vaddr_t    [NR_COMMIT_PORTS-1:0] pc;
  rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] rs1, rs2, rd;
  rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] result, wdata;

  logic                [NR_COMMIT_PORTS-1:0] trace_valid, trace_trap;
  rvfi_pkg::insn_t     [NR_COMMIT_PORTS-1:0] trace_insn;
  rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_cause, trace_rs1_rdata, trace_rs2_rdata;
  rvfi_pkg::priv_t     [NR_COMMIT_PORTS-1:0] trace_mode;
  rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] trace_rs1_addr, trace_rs2_addr, trace_rd_addr;
  rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_rd_wdata, trace_mem_wdata, trace_mem_rdata;
  rvfi_pkg::vaddr_t    [NR_COMMIT_PORTS-1:0] trace_pc, trace_mem_addr;
  rvfi_pkg::be_t       [NR_COMMIT_PORTS-1:0] trace_mem_rmask, trace_mem_wmask;

  `include "rvfi_model.svh"

  rvfi_tracer #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS),
    .NR_SB_ENTRIES  (NR_SB_ENTRIES)
  ) dut_i (
    .clk_i(clk), .rst_ni(rst_n), .fetch_valid_i(fetch_valid), .fetch_insn_i(fetch_insn),
    .is_compressed_i(is_compressed), .issue_ack_i(issue_ack), .flush_i(flush),
    .decoded_valid_i(decoded_valid), .decoded_ack_i(decoded_ack),
    .flush_unissued_i(flush_unissued), .issue_id_i(issue_id),
    .rs1_fwd_i(rs1_fwd), .rs2_fwd_i(rs2_fwd), .commit_ptr_i(commit_ptr),
    .commit_ack_i(commit_ack), .commit_valid_i(commit_valid), .ex_valid_i(ex_valid),
    .ex_cause_i(ex_cause), .priv_i(priv), .debug_mode_i(debug_mode), .pc_i(pc),
    .rs1_i(rs1), .rs2_i(rs2), .rd_i(rd), .result_i(result), .wdata_i(wdata),
    .lsu_valid_i(lsu_valid), .lsu_is_load_i(lsu_is_load), .lsu_is_store_i(lsu_is_store),
    .lsu_id_i(lsu_id), .lsu_addr_i(lsu_addr), .lsu_be_i(lsu_be), .lsu_wdata_i(lsu_wdata),
    .trace_valid_o(trace_valid), .trace_insn_o(trace_insn), .trace_trap_o(trace_trap),
    .trace_cause_o(trace_cause), .trace_mode_o(trace_mode),
    .trace_rs1_addr_o(trace_rs1_addr), .trace_rs2_addr_o(trace_rs2_addr),
    .trace_rd_addr_o(trace_rd_addr), .trace_rs1_rdata_o(trace_rs1_rdata),
    .trace_rs2_rdata_o(trace_rs2_rdata), .trace_rd_wdata_o(trace_rd_wdata),
    .trace_pc_o(trace_pc), .trace_mem_addr_o(trace_mem_addr),
    .trace_mem_rmask_o(trace_mem_rmask), .trace_mem_wmask_o(trace_mem_wmask),
    .trace_mem_wdata_o(trace_mem_wdata), .trace_mem_rdata_o(trace_mem_rdata)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Stops a run that never reaches its end
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Errors found");
      $fatal(1, "Simulation timeout");
    end
  end

  // ------------------------------------------------------------------
  // Stimulus and checks
  // ------------------------------------------------------------------
  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Fail at %0t ns: %s expected %h actual %h", $time, name, exp, act);
      $display("Errors found");
      $fatal(1, "Trace output mismatch");
    end
  endtask

  task automatic init_inputs();
    {fetch_valid, is_compressed, issue_ack, flush} = '0;
    {decoded_valid, decoded_ack, flush_unissued} = '0;
    {ex_valid, debug_mode, lsu_valid, lsu_is_load, lsu_is_store} = '0;
    {issue_id, lsu_id, fetch_insn, rs1_fwd, rs2_fwd, ex_cause} = '0;
    {lsu_wdata, lsu_addr, lsu_be, priv} = '0;
    {commit_ptr, commit_ack, commit_valid, pc, rs1, rs2, rd, result, wdata} = '0;
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    r = $random(seed);
    fetch_valid    = r[0];
    is_compressed  = r[1];
    issue_ack      = r[2];
    flush          = (r[5:3] == 3'd0);   // Rare
    flush_unissued = (r[8:6] == 3'd0);
    decoded_valid  = r[9];
    decoded_ack    = r[10];
    ex_valid       = (r[12:11] == 2'd0);
    debug_mode     = (r[14:13] == 2'd0);
    lsu_valid      = r[15];
    lsu_is_load    = r[16];
    lsu_is_store   = r[17];
    commit_ack     = r[19:18];
    commit_valid   = r[21:20];
    priv           = r[23:22];
    case (r[25:24])                       // Mostly ecall causes
      2'd0:    ex_cause = 32'd8;
      2'd1:    ex_cause = 32'd9;
      2'd2:    ex_cause = 32'd11;
      default: ex_cause = {28'h0, r[29:26]};
    endcase
    r = $random(seed);
    issue_id   = r[2:0];
    lsu_id     = r[5:3];
    lsu_be     = r[9:6];
    fetch_insn = $random(seed);
    rs1_fwd    = $random(seed);
    rs2_fwd    = $random(seed);
    lsu_addr   = $random(seed);
    lsu_wdata  = $random(seed);
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      r = $random(seed);
      commit_ptr[p] = r[ID_W-1:0];
      rs1[p]        = r[7:3];
      rs2[p]        = r[12:8];
      rd[p]         = r[17:13];
      pc[p]         = $random(seed);
      result[p]     = $random(seed);
      wdata[p]      = $random(seed);
    end
  endtask

  task automatic compare_record();
    string s;
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      s = $sformatf("[%0d]", p);
      check_value({"trace_valid_o", s},
                  32'(valid_rule(commit_ack[p], commit_valid[p], ex_valid, ex_cause)),
                  32'(trace_valid[p]));
      check_value({"trace_trap_o", s}, 32'(commit_valid[p] && ex_valid), 32'(trace_trap[p]));
      check_value({"trace_insn_o", s}, m_insn[commit_ptr[p]], trace_insn[p]);
      check_value({"trace_cause_o", s}, ex_cause, trace_cause[p]);
      check_value({"trace_mode_o", s}, 32'(mode_rule(debug_mode, priv)), 32'(trace_mode[p]));
      check_value({"trace_rs1_addr_o", s}, 32'(rs1[p]), 32'(trace_rs1_addr[p]));
      check_value({"trace_rs2_addr_o", s}, 32'(rs2[p]), 32'(trace_rs2_addr[p]));
      check_value({"trace_rd_addr_o", s}, 32'(rd[p]), 32'(trace_rd_addr[p]));
      check_value({"trace_rs1_rdata_o", s}, m_rs1[commit_ptr[p]], trace_rs1_rdata[p]);
      check_value({"trace_rs2_rdata_o", s}, m_rs2[commit_ptr[p]], trace_rs2_rdata[p]);
      check_value({"trace_rd_wdata_o", s}, wdata[p], trace_rd_wdata[p]);
      check_value({"trace_pc_o", s}, pc[p], trace_pc[p]);
      check_value({"trace_mem_addr_o", s}, m_addr[commit_ptr[p]], trace_mem_addr[p]);
      check_value({"trace_mem_rmask_o", s}, 32'(m_rmask[commit_ptr[p]]),
                  32'(trace_mem_rmask[p]));
      check_value({"trace_mem_wmask_o", s}, 32'(m_wmask[commit_ptr[p]]),
                  32'(trace_mem_wmask[p]));
      check_value({"trace_mem_wdata_o", s}, m_wdata[commit_ptr[p]], trace_mem_wdata[p]);
      check_value({"trace_mem_rdata_o", s}, result[p], trace_mem_rdata[p]);
    end
  endtask

  initial begin
    seed  = 32'ha144_5645;
    rst_n = 1'b0;
    init_inputs();
    clear_model();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    compare_record();                 // Idle record straight out of reset
    for (int c = 0; c < NUM_CYCLES; c++) begin
      drive_inputs();
      @(posedge clk);
      clock_model();
      @(negedge clk);
      compare_record();
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/rvfi_tracer.sv
// Instruction trace unit top: probe capture, issue table and commit packing
`timescale 1ns/1ps
`default_nettype none

module rvfi_tracer #(
  parameter  int unsigned NR_COMMIT_PORTS = 2,
  parameter  int unsigned NR_SB_ENTRIES   = 8,
  localparam int unsigned ID_W = (NR_SB_ENTRIES > 1) ? $clog2(NR_SB_ENTRIES) : 1
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_ni,
  // Fetch and issue probes
  input  wire logic                                 fetch_valid_i,
  input  wire rvfi_pkg::insn_t                      fetch_insn_i,
  input  wire logic                                 is_compressed_i,
  input  wire logic                                 issue_ack_i,
  input  wire logic                                 flush_i,
  input  wire logic                                 decoded_valid_i,
  input  wire logic                                 decoded_ack_i,
  input  wire logic                                 flush_unissued_i,
  input  wire logic [ID_W-1:0]                      issue_id_i,
  input  wire rvfi_pkg::xlen_t                      rs1_fwd_i,
  input  wire rvfi_pkg::xlen_t                      rs2_fwd_i,
  // Commit probes
  input  wire logic [NR_COMMIT_PORTS-1:0][ID_W-1:0] commit_ptr_i,
  input  wire logic [NR_COMMIT_PORTS-1:0]           commit_ack_i,
  input  wire logic [NR_COMMIT_PORTS-1:0]           commit_valid_i,
  input  wire logic                                 ex_valid_i,
  input  wire rvfi_pkg::xlen_t                      ex_cause_i,
  input  wire rvfi_pkg::priv_t                      priv_i,
  input  wire logic                                 debug_mode_i,
  input  rvfi_pkg::vaddr_t    [NR_COMMIT_PORTS-1:0] pc_i,
  input  rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] rs1_i,
  input  rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] rs2_i,
  input  rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] rd_i,
  input  rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] result_i,
  input  rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] wdata_i,
  // Load/store probes
  input  wire logic                                 lsu_valid_i,
  input  wire logic                                 lsu_is_load_i,
  input  wire logic                                 lsu_is_store_i,
  input  wire logic [ID_W-1:0]                      lsu_id_i,
  input  wire rvfi_pkg::vaddr_t                     lsu_addr_i,
  input  wire rvfi_pkg::be_t                        lsu_be_i,
  input  wire rvfi_pkg::xlen_t                      lsu_wdata_i,
  // Trace records
  output logic                [NR_COMMIT_PORTS-1:0] trace_valid_o,
  output rvfi_pkg::insn_t     [NR_COMMIT_PORTS-1:0] trace_insn_o,
  output logic                [NR_COMMIT_PORTS-1:0] trace_trap_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_cause_o,
  output rvfi_pkg::priv_t     [NR_COMMIT_PORTS-1:0] trace_mode_o,
  output rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] trace_rs1_addr_o,
  output rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] trace_rs2_addr_o,
  output rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] trace_rd_addr_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_rs1_rdata_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_rs2_rdata_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_rd_wdata_o,
  output rvfi_pkg::vaddr_t    [NR_COMMIT_PORTS-1:0] trace_pc_o,
  output rvfi_pkg::vaddr_t    [NR_COMMIT_PORTS-1:0] trace_mem_addr_o,
  output rvfi_pkg::be_t       [NR_COMMIT_PORTS-1:0] trace_mem_rmask_o,
  output rvfi_pkg::be_t       [NR_COMMIT_PORTS-1:0] trace_mem_wmask_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_mem_wdata_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_mem_rdata_o
);

  rvfi_issue_if #(.NR_SB_ENTRIES(NR_SB_ENTRIES)) issue_bus ();
  rvfi_lsu_if   #(.NR_SB_ENTRIES(NR_SB_ENTRIES)) lsu_bus ();

  rvfi_pkg::insn_t  [NR_COMMIT_PORTS-1:0] tbl_insn;
  rvfi_pkg::xlen_t  [NR_COMMIT_PORTS-1:0] tbl_rs1;
  rvfi_pkg::xlen_t  [NR_COMMIT_PORTS-1:0] tbl_rs2;
  rvfi_pkg::vaddr_t [NR_COMMIT_PORTS-1:0] tbl_addr;
  rvfi_pkg::be_t    [NR_COMMIT_PORTS-1:0] tbl_rmask;
  rvfi_pkg::be_t    [NR_COMMIT_PORTS-1:0] tbl_wmask;
  rvfi_pkg::xlen_t  [NR_COMMIT_PORTS-1:0] tbl_wdata;

  // ------------------------------------------------------------------
  // Memory annotation: byte enable becomes a read or a write mask
  // ------------------------------------------------------------------
  assign lsu_bus.id    = lsu_id_i;
  assign lsu_bus.addr  = lsu_addr_i;
  assign lsu_bus.rmask = (lsu_valid_i && lsu_is_load_i)  ? lsu_be_i : '0;
  assign lsu_bus.wmask = (lsu_valid_i && lsu_is_store_i) ? lsu_be_i : '0;
  assign lsu_bus.wdata = lsu_wdata_i;

  rvfi_id_capture #(
    .NR_SB_ENTRIES(NR_SB_ENTRIES)
  ) u_id_capture (
    .clk_i, .rst_ni, .fetch_valid_i, .fetch_insn_i, .is_compressed_i,
    .issue_ack_i, .flush_i, .decoded_valid_i, .decoded_ack_i, .flush_unissued_i,
    .issue_id_i, .rs1_fwd_i, .rs2_fwd_i,
    .issue_o (issue_bus.issue)
  );

  rvfi_issue_table #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS),
    .NR_SB_ENTRIES  (NR_SB_ENTRIES)
  ) u_issue_table (
    .clk_i, .rst_ni,
    .issue_i     (issue_bus.tbl),
    .lsu_i       (lsu_bus.tbl),
    .commit_ptr_i,
    .rd_insn_o   (tbl_insn),
    .rd_rs1_o    (tbl_rs1),
    .rd_rs2_o    (tbl_rs2),
    .rd_addr_o   (tbl_addr),
    .rd_rmask_o  (tbl_rmask),
    .rd_wmask_o  (tbl_wmask),
    .rd_wdata_o  (tbl_wdata)
  );

  rvfi_commit_pack #(
    .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
  ) u_commit_pack (
    .commit_ack_i, .commit_valid_i, .ex_valid_i, .ex_cause_i, .priv_i, .debug_mode_i,
    .pc_i, .rs1_i, .rs2_i, .rd_i, .result_i, .wdata_i,
    .tbl_insn_i  (tbl_insn),
    .tbl_rs1_i   (tbl_rs1),
    .tbl_rs2_i   (tbl_rs2),
    .tbl_addr_i  (tbl_addr),
    .tbl_rmask_i (tbl_rmask),
    .tbl_wmask_i (tbl_wmask),
    .tbl_wdata_i (tbl_wdata),
    .trace_valid_o, .trace_insn_o, .trace_trap_o, .trace_cause_o, .trace_mode_o,
    .trace_rs1_addr_o, .trace_rs2_addr_o, .trace_rd_addr_o,
    .trace_rs1_rdata_o, .trace_rs2_rdata_o, .trace_rd_wdata_o, .trace_pc_o,
    .trace_mem_addr_o, .trace_mem_rmask_o, .trace_mem_wmask_o,
    .trace_mem_wdata_o, .trace_mem_rdata_o
  );

endmodule

`default_nettype wire

//--- src/rvfi_commit_pack.sv
// Commit packer: forms one trace record per commit port from probes and table data
`timescale 1ns/1ps
`default_nettype none

module rvfi_commit_pack #(
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  wire logic        [NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  wire logic        [NR_COMMIT_PORTS-1:0] commit_valid_i,
  input  wire logic                              ex_valid_i,
  input  wire rvfi_pkg::xlen_t                   ex_cause_i,
  input  wire rvfi_pkg::priv_t                   priv_i,
  input  wire logic                              debug_mode_i,
  input  rvfi_pkg::vaddr_t    [NR_COMMIT_PORTS-1:0] pc_i,
  input  rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] rs1_i,
  input  rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] rs2_i,
  input  rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] rd_i,
  input  rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] result_i,
  input  rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] wdata_i,
  // Table read values
  input  rvfi_pkg::insn_t     [NR_COMMIT_PORTS-1:0] tbl_insn_i,
  input  rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] tbl_rs1_i,
  input  rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] tbl_rs2_i,
  input  rvfi_pkg::vaddr_t    [NR_COMMIT_PORTS-1:0] tbl_addr_i,
  input  rvfi_pkg::be_t       [NR_COMMIT_PORTS-1:0] tbl_rmask_i,
  input  rvfi_pkg::be_t       [NR_COMMIT_PORTS-1:0] tbl_wmask_i,
  input  rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] tbl_wdata_i,
  // Trace record
  output logic                [NR_COMMIT_PORTS-1:0] trace_valid_o,
  output rvfi_pkg::insn_t     [NR_COMMIT_PORTS-1:0] trace_insn_o,
  output logic                [NR_COMMIT_PORTS-1:0] trace_trap_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_cause_o,
  output rvfi_pkg::priv_t     [NR_COMMIT_PORTS-1:0] trace_mode_o,
  output rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] trace_rs1_addr_o,
  output rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] trace_rs2_addr_o,
  output rvfi_pkg::reg_addr_t [NR_COMMIT_PORTS-1:0] trace_rd_addr_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_rs1_rdata_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_rs2_rdata_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_rd_wdata_o,
  output rvfi_pkg::vaddr_t    [NR_COMMIT_PORTS-1:0] trace_pc_o,
  output rvfi_pkg::vaddr_t    [NR_COMMIT_PORTS-1:0] trace_mem_addr_o,
  output rvfi_pkg::be_t       [NR_COMMIT_PORTS-1:0] trace_mem_rmask_o,
  output rvfi_pkg::be_t       [NR_COMMIT_PORTS-1:0] trace_mem_wmask_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_mem_wdata_o,
  output rvfi_pkg::xlen_t     [NR_COMMIT_PORTS-1:0] trace_mem_rdata_o
);

  logic is_ecall;  // Ecalls still retire when trapping

  assign is_ecall = (ex_cause_i == rvfi_pkg::CAUSE_ECALL_U) ||
                    (ex_cause_i == rvfi_pkg::CAUSE_ECALL_S) ||
                    (ex_cause_i == rvfi_pkg::CAUSE_ECALL_M);

  always_comb begin
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      trace_trap_o[i]  = commit_valid_i[i] && ex_valid_i;
      trace_valid_o[i] = (commit_ack_i[i] && !ex_valid_i) || (trace_trap_o[i] && is_ecall);
      trace_insn_o[i]  = tbl_insn_i[i];
      trace_cause_o[i] = ex_cause_i;
      trace_mode_o[i]  = debug_mode_i ? rvfi_pkg::DEBUG_MODE : priv_i;

      trace_rs1_addr_o[i]  = rs1_i[i];
      trace_rs2_addr_o[i]  = rs2_i[i];
      trace_rd_addr_o[i]   = rd_i[i];
      trace_rs1_rdata_o[i] = tbl_rs1_i[i];   // Operands as seen at issue
      trace_rs2_rdata_o[i] = tbl_rs2_i[i];
      trace_rd_wdata_o[i]  = wdata_i[i];
      trace_pc_o[i]        = pc_i[i];

      trace_mem_addr_o[i]  = tbl_addr_i[i];
      trace_mem_rmask_o[i] = tbl_rmask_i[i];
      trace_mem_wmask_o[i] = tbl_wmask_i[i];
      trace_mem_wdata_o[i] = tbl_wdata_i[i];
      trace_mem_rdata_o[i] = result_i[i];    // Load data is the commit result
    end
  end

endmodule

`default_nettype wire

//--- src/rvfi_issue_table.sv
// Issue table: per-transaction instruction, operands and memory annotation
`timescale 1ns/1ps
`default_nettype none

module rvfi_issue_table #(
  parameter  int unsigned NR_COMMIT_PORTS = 2,
  parameter  int unsigned NR_SB_ENTRIES   = 8,
  localparam int unsigned ID_W = (NR_SB_ENTRIES > 1) ? $clog2(NR_SB_ENTRIES) : 1
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  rst_ni,
  rvfi_issue_if.tbl                                  issue_i,
  rvfi_lsu_if.tbl                                    lsu_i,
  input  wire logic [NR_COMMIT_PORTS-1:0][ID_W-1:0]  commit_ptr_i,
  output rvfi_pkg::insn_t  [NR_COMMIT_PORTS-1:0]     rd_insn_o,
  output rvfi_pkg::xlen_t  [NR_COMMIT_PORTS-1:0]     rd_rs1_o,
  output rvfi_pkg::xlen_t  [NR_COMMIT_PORTS-1:0]     rd_rs2_o,
  output rvfi_pkg::vaddr_t [NR_COMMIT_PORTS-1:0]     rd_addr_o,
  output rvfi_pkg::be_t    [NR_COMMIT_PORTS-1:0]     rd_rmask_o,
  output rvfi_pkg::be_t    [NR_COMMIT_PORTS-1:0]     rd_wmask_o,
  output rvfi_pkg::xlen_t  [NR_COMMIT_PORTS-1:0]     rd_wdata_o
);

  // ------------------------------------------------------------------
  // Storage
  // ------------------------------------------------------------------
  rvfi_pkg::insn_t  insn_q  [NR_SB_ENTRIES];
  rvfi_pkg::xlen_t  rs1_q   [NR_SB_ENTRIES];
  rvfi_pkg::xlen_t  rs2_q   [NR_SB_ENTRIES];
  rvfi_pkg::vaddr_t addr_q  [NR_SB_ENTRIES];  // Load or store address
  rvfi_pkg::be_t    rmask_q [NR_SB_ENTRIES];
  rvfi_pkg::be_t    wmask_q [NR_SB_ENTRIES];
  rvfi_pkg::xlen_t  wdata_q [NR_SB_ENTRIES];  // Store data

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NR_SB_ENTRIES; i++) begin
        insn_q[i]  <= '0;
        rs1_q[i]   <= '0;
        rs2_q[i]   <= '0;
        addr_q[i]  <= '0;
        rmask_q[i] <= '0;
        wmask_q[i] <= '0;
        wdata_q[i] <= '0;
      end
    end else begin
      // A new issue starts the entry afresh
      if (issue_i.wr_valid) begin
        insn_q[issue_i.wr_id]  <= issue_i.wr_insn;
        rs1_q[issue_i.wr_id]   <= issue_i.rs1_data;
        rs2_q[issue_i.wr_id]   <= issue_i.rs2_data;
        addr_q[issue_i.wr_id]  <= '0;
        rmask_q[issue_i.wr_id] <= '0;
        wmask_q[issue_i.wr_id] <= '0;
        wdata_q[issue_i.wr_id] <= '0;
      end

      // Annotation comes later in the block, so it overrides a same-id issue
      if (lsu_i.rmask != '0) begin
        addr_q[lsu_i.id]  <= lsu_i.addr;
        rmask_q[lsu_i.id] <= lsu_i.rmask;
      end else if (lsu_i.wmask != '0) begin
        addr_q[lsu_i.id]  <= lsu_i.addr;
        wmask_q[lsu_i.id] <= lsu_i.wmask;
        wdata_q[lsu_i.id] <= lsu_i.wdata;
      end
    end
  end

  // ------------------------------------------------------------------
  // Read ports, one per commit port
  // ------------------------------------------------------------------
  always_comb begin
    for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
      rd_insn_o[p]  = insn_q[commit_ptr_i[p]];
      rd_rs1_o[p]   = rs1_q[commit_ptr_i[p]];
      rd_rs2_o[p]   = rs2_q[commit_ptr_i[p]];
      rd_addr_o[p]  = addr_q[commit_ptr_i[p]];
      rd_rmask_o[p] = rmask_q[commit_ptr_i[p]];
      rd_wmask_o[p] = wmask_q[commit_ptr_i[p]];
      rd_wdata_o[p] = wdata_q[commit_ptr_i[p]];
    end
  end

endmodule

`default_nettype wire

//--- src/rvfi_id_capture.sv
// Decode capture: holds the fetched word until issue and raises the table write
`timescale 1ns/1ps
`default_nettype none

module rvfi_id_capture #(
  parameter  int unsigned NR_SB_ENTRIES = 8,
  localparam int unsigned ID_W = (NR_SB_ENTRIES > 1) ? $clog2(NR_SB_ENTRIES) : 1
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            fetch_valid_i,
  input  wire rvfi_pkg::insn_t fetch_insn_i,
  input  wire logic            is_compressed_i,
  input  wire logic            issue_ack_i,
  input  wire logic            flush_i,
  input  wire logic            decoded_valid_i,
  input  wire logic            decoded_ack_i,
  input  wire logic            flush_unissued_i,
  input  wire logic [ID_W-1:0] issue_id_i,
  input  wire rvfi_pkg::xlen_t rs1_fwd_i,
  input  wire rvfi_pkg::xlen_t rs2_fwd_i,
  rvfi_issue_if.issue          issue_o
);

  logic            valid_q, valid_d;
  rvfi_pkg::insn_t insn_q, insn_d;

  always_comb begin
    valid_d = valid_q;
    insn_d  = insn_q;
    if (issue_ack_i) valid_d = 1'b0;   // Issue stage took the word
    // Room in the holder, or it empties this cycle
    if ((!valid_q || issue_ack_i) && fetch_valid_i) begin
      valid_d = 1'b1;
      insn_d  = is_compressed_i ? {16'h0000, fetch_insn_i[15:0]} : fetch_insn_i;
    end
    if (flush_i) valid_d = 1'b0;       // Flush wins over a new fetch
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      insn_q  <= '0;
    end else begin
      valid_q <= valid_d;
      insn_q  <= insn_d;
    end
  end

  // Table write on the decode handshake
  assign issue_o.wr_valid = decoded_valid_i && decoded_ack_i && !flush_unissued_i;
  assign issue_o.wr_id    = issue_id_i;
  assign issue_o.wr_insn  = insn_q;
  assign issue_o.rs1_data = rs1_fwd_i;
  assign issue_o.rs2_data = rs2_fwd_i;

endmodule

`default_nettype wire

//--- src/rvfi_lsu_if.sv
// Memory annotation channel from the load/store probes into the issue table
`timescale 1ns/1ps
`default_nettype none

interface rvfi_lsu_if #(
  parameter int unsigned NR_SB_ENTRIES = 8
);

  localparam int unsigned ID_W = (NR_SB_ENTRIES > 1) ? $clog2(NR_SB_ENTRIES) : 1;

  logic [ID_W-1:0]  id;     // Transaction id of the memory op
  rvfi_pkg::vaddr_t addr;
  rvfi_pkg::be_t    rmask;  // Nonzero only for a load
  rvfi_pkg::be_t    wmask;  // Nonzero only for a store
  rvfi_pkg::xlen_t  wdata;

  modport lsu (
    output id, addr, rmask, wmask, wdata
  );

  modport tbl (
    input id, addr, rmask, wmask, wdata
  );

endinterface

`default_nettype wire

//--- src/rvfi_issue_if.sv
// Issue-time write channel from instruction capture into the issue table
`timescale 1ns/1ps
`default_nettype none

interface rvfi_issue_if #(
  parameter int unsigned NR_SB_ENTRIES = 8
);

  localparam int unsigned ID_W = (NR_SB_ENTRIES > 1) ? $clog2(NR_SB_ENTRIES) : 1;

  logic              wr_valid;  // Entry write strobe
  logic [ID_W-1:0]   wr_id;     // Transaction id being issued
  rvfi_pkg::insn_t   wr_insn;
  rvfi_pkg::xlen_t   rs1_data;  // Forwarded operands
  rvfi_pkg::xlen_t   rs2_data;

  modport issue (
    output wr_valid, wr_id, wr_insn, rs1_data, rs2_data
  );

  // Receiver side, on the table
  modport tbl (
    input wr_valid, wr_id, wr_insn, rs1_data, rs2_data
  );

endinterface

`default_nettype wire

//--- src/rvfi_pkg.sv
// Trace unit package: data widths, field types and trap cause codes
`default_nettype none

package rvfi_pkg;

  // ------------------------------------------------------------------
  // Widths
  // ------------------------------------------------------------------
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0]   xlen_t;      // Register or data value
  typedef logic [31:0]       insn_t;      // Instruction word, compressed ones zero-extended
  typedef logic [XLEN-1:0]   vaddr_t;     // Virtual address
  typedef logic [XLEN/8-1:0] be_t;        // One bit per data byte
  typedef logic [4:0]        reg_addr_t;  // Architectural register index
  typedef logic [1:0]        priv_t;      // Privilege level

  // ------------------------------------------------------------------
  // Mode and cause codes
  // ------------------------------------------------------------------

  // Reported as the mode while the hart sits in debug mode
  localparam priv_t DEBUG_MODE = 2'd2;

  // Environment calls retire even though they raise an exception
  localparam xlen_t CAUSE_ECALL_U = 32'd8;
  localparam xlen_t CAUSE_ECALL_S = 32'd9;
  localparam xlen_t CAUSE_ECALL_M = 32'd11;

endpackage

`default_nettype wire
